// ==== hdl/axis_tracker.sv ====
// Single-axis tracker
// Position and velocity state with a constant-velocity prediction and a
// steady-state gain correction by the measurement residual

`timescale 1ns/100ps

`include "kalman_consts.svh"

module axis_tracker (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     i_clear,
	input  kalman_pkg::kalman_gain_t i_gains,
	input  kalman_pkg::fix_t         i_meas,
	input  logic                     i_predict,
	input  logic                     i_update,
	output kalman_pkg::fix_t         o_pos
);

	import kalman_pkg::*;

	fix_t pos;
	fix_t vel;
	fix_t pos_pred;
	fix_t residual;
	fix_t dt_vel;
	fix_t kpos_res;
	fix_t kvel_res;

	// Fixed-point product, floor rounding, wraps to the word width
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [2*`KALMAN_ARCH_W-1:0] prod;
		logic signed [2*`KALMAN_ARCH_W-1:0] prod_sh;
		prod    = a * b;
		prod_sh = prod >>> `KALMAN_ARCH_F;
		return prod_sh[`KALMAN_ARCH_W-1:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////

	assign dt_vel   = fix_mul(i_gains.dt, vel);
	assign residual = i_meas - pos_pred;
	assign kpos_res = fix_mul(i_gains.kpos, residual);
	assign kvel_res = fix_mul(i_gains.kvel, residual);

	// Predicted position, taken at the end of the predict cycle
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			pos_pred <= '0;
		end else if (i_clear) begin
			pos_pred <= '0;
		end else if (i_predict) begin
			pos_pred <= pos + dt_vel;
		end
	end

	// Corrected state, taken at the end of the update cycle
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			pos <= '0;
			vel <= '0;
		end else if (i_clear) begin
			pos <= '0;
			vel <= '0;
		end else if (i_update) begin
			pos <= pos_pred + kpos_res;
			vel <= vel + kvel_res;
		end
	end

	assign o_pos = pos;

endmodule

// ==== hdl/estimate_collector.sv ====
// Estimate collector
// Cuts both positions to display width one cycle after an update,
// flags them with a single-cycle valid and counts the estimates

`timescale 1ns/100ps

`include "kalman_consts.svh"

module estimate_collector (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic                  i_clear,
	input  kalman_pkg::axis_vec_t i_pos,
	input  logic                  i_update,
	output kalman_pkg::disp_t     o_z_x_new,
	output kalman_pkg::disp_t     o_z_y_new,
	output logic                  o_est_valid,
	output kalman_pkg::cnt_t      o_est_count
);

	import kalman_pkg::*;

	// High in the cycle after the update, when the new positions are settled
	logic upd_q;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			upd_q       <= 1'b0;
			o_est_valid <= 1'b0;
			o_z_x_new   <= '0;
			o_z_y_new   <= '0;
		end else begin
			upd_q       <= i_update;
			o_est_valid <= upd_q;
			if (upd_q) begin
				// Integer part of the position, low display bits
				o_z_x_new <= i_pos[0][`KALMAN_ARCH_F+`KALMAN_DISP_W-1:`KALMAN_ARCH_F];
				o_z_y_new <= i_pos[1][`KALMAN_ARCH_F+`KALMAN_DISP_W-1:`KALMAN_ARCH_F];
			end
		end
	end

	// Wraps at the counter width
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			o_est_count <= '0;
		end else if (i_clear) begin
			o_est_count <= '0;
		end else if (upd_q) begin
			o_est_count <= o_est_count + 1'b1;
		end
	end

endmodule

// ==== hdl/kalman_consts.svh ====
// Kalman tracker constants
// Fixed-point format, display width, APB register map and reset values

`ifndef KALMAN_CONSTS_SVH
`define KALMAN_CONSTS_SVH

// Fixed-point format, two's complement
`define KALMAN_ARCH_W   18
`define KALMAN_ARCH_F   6

// Measurement and estimate coordinates
`define KALMAN_DISP_W   11
`define KALMAN_NUM_AXES 2

// Estimate counter and APB address widths
`define KALMAN_CNT_W    16
`define KALMAN_ADDR_W   8

// Register map
`define KALMAN_REG_CTRL  8'h00
`define KALMAN_REG_DT    8'h04
`define KALMAN_REG_KPOS  8'h08
`define KALMAN_REG_KVEL  8'h0C
`define KALMAN_REG_COUNT 8'h10

// Reset values in fixed point, 1.0 / 0.5 / 0.25
`define KALMAN_DT_RST   64
`define KALMAN_KPOS_RST 32
`define KALMAN_KVEL_RST 16

`endif

// ==== hdl/kalman_pkg.sv ====
// Kalman tracker types
// Fixed-point words, per-axis vectors, gain set, APB bundles and sequencer states

`include "kalman_consts.svh"

package kalman_pkg;

	//////////////////////////////////////////////////////////////////////
	// Plain vectors
	//////////////////////////////////////////////////////////////////////

	// Signed fixed point with KALMAN_ARCH_F fraction bits
	typedef logic signed [`KALMAN_ARCH_W-1:0] fix_t;

	// Unsigned pixel coordinate
	typedef logic [`KALMAN_DISP_W-1:0] disp_t;

	// Number of estimates produced since reset or clear
	typedef logic [`KALMAN_CNT_W-1:0] cnt_t;

	// One word per axis, index 0 is x and index 1 is y
	typedef fix_t [`KALMAN_NUM_AXES-1:0] axis_vec_t;

	//////////////////////////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////////////////////////

	// Steady-state filter settings shared by all axes
	typedef struct packed {
		fix_t dt;
		fix_t kpos;
		fix_t kvel;
	} kalman_gain_t;

	typedef struct packed {
		logic                      psel;
		logic                      penable;
		logic                      pwrite;
		logic [`KALMAN_ADDR_W-1:0] paddr;
		logic [31:0]               pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Measurement sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_PREDICT,
		SEQ_UPDATE
	} seq_state_e;

endpackage

// ==== hdl/kalman_regs.sv ====
// Kalman tracker APB register block
// Holds the time step and the two steady-state gains, issues the clear
// pulse and reads back the estimate count. No wait states.

`timescale 1ns/100ps

`include "kalman_consts.svh"

module kalman_regs (
	input  logic                     clk,
	input  logic                     aresetn,
	input  kalman_pkg::apb_req_t     i_apb,
	input  kalman_pkg::cnt_t         i_est_count,
	output kalman_pkg::apb_rsp_t     o_apb,
	output kalman_pkg::kalman_gain_t o_gains,
	output logic                     o_clear
);

	import kalman_pkg::*;

	logic        access;
	logic        wr_en;
	logic        addr_ok;
	logic        count_wr;
	logic [31:0] rdata;

	// Fixed-point registers read back sign-extended
	function automatic logic [31:0] ext_fix(input fix_t v);
		return {{(32-`KALMAN_ARCH_W){v[`KALMAN_ARCH_W-1]}}, v};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Access decode
	//////////////////////////////////////////////////////////////////////

	// Access phase is the second cycle of every transfer
	assign access   = i_apb.psel && i_apb.penable;
	assign wr_en    = access && i_apb.pwrite;
	assign count_wr = i_apb.pwrite && (i_apb.paddr == `KALMAN_REG_COUNT);

	always_comb begin
		addr_ok = 1'b1;
		rdata   = '0;
		case (i_apb.paddr)
			`KALMAN_REG_CTRL: rdata = '0;
			`KALMAN_REG_DT: rdata = ext_fix(o_gains.dt);
			`KALMAN_REG_KPOS: rdata = ext_fix(o_gains.kpos);
			`KALMAN_REG_KVEL: rdata = ext_fix(o_gains.kvel);
			`KALMAN_REG_COUNT: rdata = {{(32-`KALMAN_CNT_W){1'b0}}, i_est_count};
			default: addr_ok = 1'b0;
		endcase
	end

	assign o_apb.prdata  = rdata;
	assign o_apb.pready  = 1'b1;
	assign o_apb.pslverr = access && (!addr_ok || count_wr);

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			o_gains.dt   <= fix_t'(`KALMAN_DT_RST);
			o_gains.kpos <= fix_t'(`KALMAN_KPOS_RST);
			o_gains.kvel <= fix_t'(`KALMAN_KVEL_RST);
		end else if (wr_en) begin
			case (i_apb.paddr)
				`KALMAN_REG_DT: o_gains.dt <= fix_t'(i_apb.pwdata[`KALMAN_ARCH_W-1:0]);
				`KALMAN_REG_KPOS: o_gains.kpos <= fix_t'(i_apb.pwdata[`KALMAN_ARCH_W-1:0]);
				`KALMAN_REG_KVEL: o_gains.kvel <= fix_t'(i_apb.pwdata[`KALMAN_ARCH_W-1:0]);
				default: ;
			endcase
		end
	end

	// CTRL bit 0 is self-clearing, one cycle after the write
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			o_clear <= 1'b0;
		end else begin
			o_clear <= wr_en && (i_apb.paddr == `KALMAN_REG_CTRL) && i_apb.pwdata[0];
		end
	end

endmodule

// ==== hdl/kalman_top.sv ====
// Kalman tracker top level
// Connects the APB registers, the measurement sequencer, one tracker
// per axis and the estimate collector

`timescale 1ns/100ps

`include "kalman_consts.svh"

module kalman_top (
	input  logic                  clk,
	input  logic                  aresetn,
	input  kalman_pkg::apb_req_t  i_apb,
	output kalman_pkg::apb_rsp_t  o_apb,
	input  kalman_pkg::disp_t     i_z_x,
	input  kalman_pkg::disp_t     i_z_y,
	input  logic                  i_meas_valid,
	output logic                  o_meas_ready,
	output kalman_pkg::disp_t     o_z_x_new,
	output kalman_pkg::disp_t     o_z_y_new,
	output logic                  o_est_valid
);

	import kalman_pkg::*;

	kalman_gain_t gains;
	logic         clear;
	axis_vec_t    meas;
	axis_vec_t    pos;
	logic         predict;
	logic         update;
	cnt_t         est_count;

	kalman_regs u_regs (
		.clk         (clk),
		.aresetn     (aresetn),
		.i_apb       (i_apb),
		.i_est_count (est_count),
		.o_apb       (o_apb),
		.o_gains     (gains),
		.o_clear     (clear)
	);

	meas_sequencer u_seq (
		.clk          (clk),
		.aresetn      (aresetn),
		.i_z_x        (i_z_x),
		.i_z_y        (i_z_y),
		.i_meas_valid (i_meas_valid),
		.o_meas_ready (o_meas_ready),
		.o_meas       (meas),
		.o_predict    (predict),
		.o_update     (update)
	);

	// The axes do not interact, so each one gets its own tracker
	for (genvar ax = 0; ax < `KALMAN_NUM_AXES; ax++) begin : g_axis
		axis_tracker u_tracker (
			.clk       (clk),
			.aresetn   (aresetn),
			.i_clear   (clear),
			.i_gains   (gains),
			.i_meas    (meas[ax]),
			.i_predict (predict),
			.i_update  (update),
			.o_pos     (pos[ax])
		);
	end

	estimate_collector u_collect (
		.clk         (clk),
		.aresetn     (aresetn),
		.i_clear     (clear),
		.i_pos       (pos),
		.i_update    (update),
		.o_z_x_new   (o_z_x_new),
		.o_z_y_new   (o_z_y_new),
		.o_est_valid (o_est_valid),
		.o_est_count (est_count)
	);

endmodule

// ==== hdl/meas_sequencer.sv ====
// Measurement sequencer
// Takes one measurement pair per valid/ready handshake, converts it to
// fixed point and steps the trackers through predict then update

`timescale 1ns/100ps

`include "kalman_consts.svh"

module meas_sequencer (
	input  logic                  clk,
	input  logic                  aresetn,
	input  kalman_pkg::disp_t     i_z_x,
	input  kalman_pkg::disp_t     i_z_y,
	input  logic                  i_meas_valid,
	output logic                  o_meas_ready,
	output kalman_pkg::axis_vec_t o_meas,
	output logic                  o_predict,
	output logic                  o_update
);

	import kalman_pkg::*;

	seq_state_e state;
	seq_state_e state_nxt;
	logic       started;
	logic       accept;

	// Integer pixel to fixed point, always positive
	function automatic fix_t to_fix(input disp_t z);
		return {{(`KALMAN_ARCH_W-`KALMAN_DISP_W-`KALMAN_ARCH_F){1'b0}}, z,
			{`KALMAN_ARCH_F{1'b0}}};
	endfunction

	// Holds ready low for the first cycle out of reset
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			started <= 1'b0;
		end else begin
			started <= 1'b1;
		end
	end

	assign o_meas_ready = started && (state == SEQ_IDLE);
	assign accept       = o_meas_ready && i_meas_valid;

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			SEQ_IDLE: if (accept) state_nxt = SEQ_PREDICT;
			SEQ_PREDICT: state_nxt = SEQ_UPDATE;
			SEQ_UPDATE: state_nxt = SEQ_IDLE;
			default: state_nxt = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= SEQ_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Step strobes follow the state directly
	assign o_predict = (state == SEQ_PREDICT);
	assign o_update  = (state == SEQ_UPDATE);

	// Measurement pair, stable until the next accept
	always_ff @(posedge clk) begin
		if (accept) begin
			o_meas[0] <= to_fix(i_z_x);
			o_meas[1] <= to_fix(i_z_y);
		end
	end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/kalman_pkg.sv
hdl/kalman_regs.sv
hdl/meas_sequencer.sv
hdl/axis_tracker.sv
hdl/estimate_collector.sv
hdl/kalman_top.sv
verif/tb_clock_gen.sv
verif/kalman_checker.sv
verif/kalman_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Kalman tracker simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module kalman_tb \
	-f project.f -o kalman_sim > build.log 2>&1 ||
	{ cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/kalman_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"

// ==== verif/kalman_checker.sv ====
// Kalman tracker protocol checker
// Concurrent assertions on the measurement handshake, the estimate
// latency and the APB error response

`timescale 1ns/100ps

`include "kalman_consts.svh"

module kalman_checker (
	input logic                 clk,
	input logic                 aresetn,
	input kalman_pkg::apb_req_t i_apb_req,
	input kalman_pkg::apb_rsp_t i_apb_rsp,
	input logic                 i_meas_valid,
	input logic                 i_meas_ready,
	input logic                 i_est_valid
);

	logic accept;
	logic apb_bad;
	int   fail_count = 0;

	assign accept = i_meas_valid && i_meas_ready;

	// Unmapped addresses and writes to COUNT take an error response
	assign apb_bad = !(i_apb_req.paddr inside {`KALMAN_REG_CTRL, `KALMAN_REG_DT,
		`KALMAN_REG_KPOS, `KALMAN_REG_KVEL, `KALMAN_REG_COUNT})
		|| (i_apb_req.pwrite && (i_apb_req.paddr == `KALMAN_REG_COUNT));

	// Ready drops for the predict and update cycles
	a_ready_low_1: assert property (@(posedge clk) disable iff (!aresetn)
		$past(accept) |-> !i_meas_ready)
		else begin
			fail_count++;
			$error("ready high one cycle after an accept");
		end

	a_ready_low_2: assert property (@(posedge clk) disable iff (!aresetn)
		$past(accept, 2) |-> !i_meas_ready)
		else begin
			fail_count++;
			$error("ready high two cycles after an accept");
		end

	// Estimate appears in the fourth cycle after its accept, and only then
	a_est_after_accept: assert property (@(posedge clk) disable iff (!aresetn)
		$past(accept, 4) |-> i_est_valid)
		else begin
			fail_count++;
			$error("no estimate four cycles after an accept");
		end

	a_est_needs_accept: assert property (@(posedge clk) disable iff (!aresetn)
		i_est_valid |-> $past(accept, 4))
		else begin
			fail_count++;
			$error("estimate without an accept four cycles earlier");
		end

	a_est_one_cycle: assert property (@(posedge clk) disable iff (!aresetn)
		i_est_valid |=> !i_est_valid)
		else begin
			fail_count++;
			$error("estimate valid longer than one cycle");
		end

	// Error only in the access phase, and there exactly for the bad accesses
	a_slverr_access: assert property (@(posedge clk) disable iff (!aresetn)
		i_apb_rsp.pslverr == (i_apb_req.psel && i_apb_req.penable && apb_bad))
		else begin
			fail_count++;
			$error("pslverr does not match the access phase and address");
		end

endmodule

// ==== verif/kalman_tb.sv ====
// Kalman tracker testbench
// Table-driven APB and measurement stimulus, estimates checked against
// a fixed-point model of the steady-state filter

`timescale 1ns/100ps

`include "kalman_consts.svh"

module kalman_tb;

	import kalman_pkg::*;

	typedef struct packed {
		logic [3:0]  test;
		logic [2:0]  kind;
		logic [7:0]  addr;
		logic [31:0] data;
		logic        err;
		disp_t       zx;
		disp_t       zy;
	} row_t;

	// Row kinds
	localparam logic [2:0] K_WR    = 3'd0;
	localparam logic [2:0] K_RD    = 3'd1;
	localparam logic [2:0] K_CNT   = 3'd2;
	localparam logic [2:0] K_OUT   = 3'd3;
	localparam logic [2:0] K_MEAS  = 3'd4;
	localparam logic [2:0] K_RAND  = 3'd5;
	localparam logic [2:0] K_BURST = 3'd6;
	localparam int NROWS = 28;

	// test, kind, address, data or count, pslverr, z_x, z_y
	localparam row_t TBL [0:NROWS-1] = '{
		'{4'd1, K_OUT, 8'h00, 32'h0, 1'b0, 11'd0, 11'd0},
		'{4'd1, K_RD, `KALMAN_REG_DT, 32'h40, 1'b0, 11'd0, 11'd0},
		'{4'd1, K_RD, `KALMAN_REG_KPOS, 32'h20, 1'b0, 11'd0, 11'd0},
		'{4'd1, K_RD, `KALMAN_REG_KVEL, 32'h10, 1'b0, 11'd0, 11'd0},
		'{4'd1, K_RD, `KALMAN_REG_COUNT, 32'h0, 1'b0, 11'd0, 11'd0},
		'{4'd2, K_MEAS, 8'h00, 32'h0, 1'b0, 11'd100, 11'd50},
		'{4'd2, K_MEAS, 8'h00, 32'h0, 1'b0, 11'd110, 11'd56},
		'{4'd2, K_MEAS, 8'h00, 32'h0, 1'b0, 11'd125, 11'd60},
		'{4'd2, K_MEAS, 8'h00, 32'h0, 1'b0, 11'd140, 11'd70},
		'{4'd2, K_MEAS, 8'h00, 32'h0, 1'b0, 11'd120, 11'd90},
		'{4'd2, K_CNT, 8'h00, 32'h0, 1'b0, 11'd0, 11'd0},
		'{4'd3, K_WR, `KALMAN_REG_DT, 32'hFFFC0060, 1'b0, 11'd0, 11'd0},
		'{4'd3, K_RD, `KALMAN_REG_DT, 32'h60, 1'b0, 11'd0, 11'd0},
		'{4'd3, K_WR, `KALMAN_REG_KPOS, 32'h30, 1'b0, 11'd0, 11'd0},
		'{4'd3, K_RD, `KALMAN_REG_KPOS, 32'h30, 1'b0, 11'd0, 11'd0},
		'{4'd3, K_WR, `KALMAN_REG_KVEL, 32'h0C, 1'b0, 11'd0, 11'd0},
		'{4'd3, K_RD, `KALMAN_REG_KVEL, 32'h0C, 1'b0, 11'd0, 11'd0},
		'{4'd3, K_WR, `KALMAN_REG_COUNT, 32'h7, 1'b1, 11'd0, 11'd0},
		'{4'd3, K_RD, 8'h14, 32'h0, 1'b1, 11'd0, 11'd0},
		'{4'd3, K_WR, 8'h20, 32'h1, 1'b1, 11'd0, 11'd0},
		'{4'd3, K_RD, `KALMAN_REG_CTRL, 32'h0, 1'b0, 11'd0, 11'd0},
		'{4'd4, K_RAND, 8'h00, 32'd12, 1'b0, 11'd0, 11'd0},
		'{4'd5, K_BURST, 8'h00, 32'd10, 1'b0, 11'd0, 11'd0},
		'{4'd5, K_CNT, 8'h00, 32'h0, 1'b0, 11'd0, 11'd0},
		'{4'd6, K_WR, `KALMAN_REG_CTRL, 32'h1, 1'b0, 11'd0, 11'd0},
		'{4'd6, K_CNT, 8'h00, 32'h0, 1'b0, 11'd0, 11'd0},
		'{4'd6, K_MEAS, 8'h00, 32'h0, 1'b0, 11'd300, 11'd200},
		'{4'd6, K_CNT, 8'h00, 32'h0, 1'b0, 11'd0, 11'd0}
	};

	string names [1:6] = '{"reset values", "tracking with reset gains", "register access",
		"tracking with new gains", "back-pressure and count", "clear"};

	logic     clk;
	logic     aresetn;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	disp_t    z_x;
	disp_t    z_y;
	logic     meas_valid;
	logic     meas_ready;
	disp_t    z_x_new;
	disp_t    z_y_new;
	logic     est_valid;

	int       seed = 12;
	int       checks;
	int       errors;
	logic     timed_out;

	// Model state, sign-extended 18-bit values
	longint   m_pos [2];
	longint   m_vel [2];
	longint   m_dt;
	longint   m_kpos;
	longint   m_kvel;
	int       m_count;

	tb_clock_gen u_clk_gen (
		.o_clk     (clk),
		.o_aresetn (aresetn)
	);

	kalman_top dut0 (
		.clk          (clk),
		.aresetn      (aresetn),
		.i_apb        (apb_req),
		.o_apb        (apb_rsp),
		.i_z_x        (z_x),
		.i_z_y        (z_y),
		.i_meas_valid (meas_valid),
		.o_meas_ready (meas_ready),
		.o_z_x_new    (z_x_new),
		.o_z_y_new    (z_y_new),
		.o_est_valid  (est_valid)
	);

	bind kalman_top kalman_checker u_chk (
		.clk          (clk),
		.aresetn      (aresetn),
		.i_apb_req    (i_apb),
		.i_apb_rsp    (o_apb),
		.i_meas_valid (i_meas_valid),
		.i_meas_ready (o_meas_ready),
		.i_est_valid  (o_est_valid)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Keep the low 18 bits as a signed value
	function automatic longint wrap18(input longint v);
		longint m;
		m = v & 64'h3FFFF;
		return (m >= 64'h20000) ? m - 64'h40000 : m;
	endfunction

	function automatic longint model_mul(input longint a, input longint b);
		return wrap18((a * b) >>> `KALMAN_ARCH_F);
	endfunction

	function automatic void model_clear();
		for (int ax = 0; ax < 2; ax++) begin
			m_pos[ax] = 0;
			m_vel[ax] = 0;
		end
		m_count = 0;
	endfunction

	function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
		case (addr)
			`KALMAN_REG_DT: m_dt = wrap18(longint'(data));
			`KALMAN_REG_KPOS: m_kpos = wrap18(longint'(data));
			`KALMAN_REG_KVEL: m_kvel = wrap18(longint'(data));
			`KALMAN_REG_CTRL: if (data[0]) model_clear();
			default: ;
		endcase
	endfunction

	// One predict and update step on both axes, returns {x, y} at display width
	function automatic logic [21:0] model_step(input disp_t zx, input disp_t zy);
		longint      z;
		longint      pred;
		longint      res;
		logic [21:0] est;
		for (int ax = 0; ax < 2; ax++) begin
			z         = longint'(ax == 0 ? zx : zy) <<< `KALMAN_ARCH_F;
			pred      = wrap18(m_pos[ax] + model_mul(m_dt, m_vel[ax]));
			res       = wrap18(z - pred);
			m_pos[ax] = wrap18(pred + model_mul(m_kpos, res));
			m_vel[ax] = wrap18(m_vel[ax] + model_mul(m_kvel, res));
		end
		est[21:11] = disp_t'(m_pos[0] >>> `KALMAN_ARCH_F);
		est[10:0]  = disp_t'(m_pos[1] >>> `KALMAN_ARCH_F);
		m_count++;
		return est;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	// Starts and ends 10 ns after a rising edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int t;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk);
		#10;
		apb_req.penable = 1'b1;
		#50;
		t = 0;
		while (!apb_rsp.pready && t < 16) begin
			@(posedge clk);
			#60;
			t++;
		end
		if (!apb_rsp.pready)
			report_timeout("APB access never completed");
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk);
		#10;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic drive_meas(input logic rnd, input disp_t zx, input disp_t zy);
		z_x        = rnd ? disp_t'($random(seed)) : zx;
		z_y        = rnd ? disp_t'($random(seed)) : zy;
		meas_valid = 1'b1;
	endtask

	// Sends n measurements and checks every estimate; with hold, valid stays
	// high and accepts must come every three cycles
	task automatic run_meas(input int n, input logic rnd, input logic hold,
		input disp_t zx, input disp_t zy);
		logic [21:0] exp_q [$];
		int          acc_q [$];
		logic [21:0] exp;
		int          sent;
		int          got;
		int          cyc;
		int          last_acc;
		logic        acc;
		logic        est;
		sent     = 0;
		got      = 0;
		cyc      = 0;
		last_acc = 0;
		drive_meas(rnd, zx, zy);
		while (got < n && cyc < 8 * n + 16) begin
			#50;
			acc = meas_valid && meas_ready;
			est = est_valid;
			if (est) begin
				exp = exp_q.pop_front();
				check_value("estimate latency", cyc - acc_q.pop_front(), 4);
				check_value("o_z_x_new", z_x_new, exp[21:11]);
				check_value("o_z_y_new", z_y_new, exp[10:0]);
				got++;
			end
			if (acc) begin
				exp_q.push_back(model_step(z_x, z_y));
				if (hold && sent > 0)
					check_value("accept interval", cyc - last_acc, 3);
				acc_q.push_back(cyc);
				last_acc = cyc;
				sent++;
			end
			@(posedge clk);
			#10;
			cyc++;
			if (acc)
				meas_valid = 1'b0;
			if (sent < n && ((acc && hold) || (est && !hold)))
				drive_meas(rnd, zx, zy);
		end
		meas_valid = 1'b0;
		if (got < n)
			report_timeout("estimates stopped arriving");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          t;
		int          cur;
		int          chk0;
		int          err0;
		row_t        r;
		logic [31:0] rdata;
		logic        err;
		apb_req    = '0;
		z_x        = '0;
		z_y        = '0;
		meas_valid = 1'b0;
		checks     = 0;
		errors     = 0;
		timed_out  = 1'b0;
		m_dt       = `KALMAN_DT_RST;
		m_kpos     = `KALMAN_KPOS_RST;
		m_kvel     = `KALMAN_KVEL_RST;
		model_clear();

		t = 0;
		while (!aresetn && t < 20) begin
			@(posedge clk);
			#50;
			t++;
		end
		if (!aresetn)
			report_timeout("reset was never released");
		@(posedge clk);
		#10;

		cur  = 1;
		chk0 = 0;
		err0 = 0;
		for (int i = 0; i < NROWS && !timed_out; i++) begin
			r = TBL[i];
			if (int'(r.test) != cur) begin
				$display("Test %0d %s: %0d checks, %0d errors", cur, names[cur],
					checks - chk0, errors - err0);
				cur  = r.test;
				chk0 = checks;
				err0 = errors;
			end
			case (r.kind)
				K_WR: begin
					apb_xfer(1'b1, r.addr, r.data, rdata, err);
					check_value("pslverr", err, r.err);
					model_write(r.addr, r.data);
				end
				K_RD: begin
					apb_xfer(1'b0, r.addr, '0, rdata, err);
					check_value("pslverr", err, r.err);
					check_value("prdata", rdata, r.data);
				end
				K_CNT: begin
					apb_xfer(1'b0, `KALMAN_REG_COUNT, '0, rdata, err);
					check_value("COUNT", rdata, m_count);
				end
				K_OUT: begin
					check_value("o_z_x_new", z_x_new, r.zx);
					check_value("o_z_y_new", z_y_new, r.zy);
					check_value("o_est_valid", est_valid, 0);
				end
				K_MEAS: run_meas(1, 1'b0, 1'b0, r.zx, r.zy);
				K_RAND: run_meas(r.data, 1'b1, 1'b0, '0, '0);
				default: run_meas(r.data, 1'b1, 1'b1, '0, '0);
			endcase
		end
		$display("Test %0d %s: %0d checks, %0d errors", cur, names[cur],
			checks - chk0, errors - err0);
		if (dut0.u_chk.fail_count != 0) begin
			$display("Protocol assertions failed %0d times", dut0.u_chk.fail_count);
			errors += dut0.u_chk.fail_count;
		end
		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and reset
// 100 ns clock, active-low reset held for the first 4 cycles

`timescale 1ns/100ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_aresetn
);

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

	// Release away from the edge so no flop sees it mid-update
	initial begin
		o_aresetn = 1'b0;
		repeat (4) @(posedge o_clk);
		#10;
		o_aresetn = 1'b1;
	end

endmodule
